/* verilog.f */
+incdir+.
drive_pkg.sv
sd_pkg.sv
cdc_sync.sv
track_loader.sv
track_buffer.sv
track_cache.sv
tb_track_cache.sv

/* run_sim.sh */
#!/bin/sh
# build the track cache testbench with verilator and run it
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -f verilog.f --top-module tb_track_cache -o sim_track_cache
./obj_dir/sim_track_cache > sim.log
cat sim.log
if grep -q "Errors found" sim.log; then
	echo "simulation FAILED"
	exit 1
fi
echo "simulation PASSED"

/* tb_track_cache.sv */
//------------------------------
// testbench for the track cache
// SD host model plus a table of drive actions run in a loop
//------------------------------
`timescale 1ns/1ps
`include "disk_cfg.svh"

module tb_track_cache
	import drive_pkg::*;
	import sd_pkg::*;
();

	localparam int NBYTES       = 16;
	localparam int NROWS        = 6;
	localparam int REQ_TIMEOUT  = 200;
	localparam int IDLE_TIMEOUT = 200;

	typedef enum logic [1:0] {ACT_NONE, ACT_MOVE, ACT_SAVE, ACT_CHANGE} act_t;

	// one test, its drive action and up to two expected requests
	typedef struct packed {
		act_t       act;
		track_t     trk;
		// set as soon as the first request shows up
		track_t     trk2;
		logic [1:0] n_req;
		logic       wr0;
		track_t     lba0;
		logic       wr1;
		track_t     lba1;
		// busy expected to drop between the two requests
		logic       idle_gap;
	} row_t;

	logic        clk = 1'b0;
	logic        reset_s;
	track_t      track;
	logic        change;
	logic        save_track;
	logic        sd_ack;
	sd_buf_t     sd_buf;
	sd_req_t     sd_req;
	logic [7:0]  sd_dout;
	drive_port_t drive;
	logic [7:0]  drive_dout;
	logic        busy;

	row_t        rows [NROWS];
	string       names [NROWS];
	// bytes put in by the drive and bytes the host read back
	logic [7:0]  written [NBYTES];
	logic [7:0]  captured [NBYTES];
	logic [31:0] lfsr;
	// track of the last load, source of the expected pattern
	track_t      last_lba;
	logic        saw_idle;
	// a wait ran out, the remaining rows are skipped
	logic        timed_out;
	int          errors;
	int          tests_failed;
	int          tests_run;

	track_cache track_cache_i (
		.clk        (clk),
		.reset_s    (reset_s),
		.track      (track),
		.change     (change),
		.save_track (save_track),
		.sd_ack     (sd_ack),
		.sd_buf     (sd_buf),
		.sd_req     (sd_req),
		.sd_dout    (sd_dout),
		.drive      (drive),
		.drive_dout (drive_dout),
		.busy       (busy)
	);

	// 8 ns period
	always #4 clk = ~clk;

	// fibonacci lfsr, taps 32 22 2 1, one step per bit
	function automatic logic [31:0] lfsr_bits(input int n);
		logic [31:0] val;
		logic        fb;
		val = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			val  = {val[30:0], fb};
		end
		return val;
	endfunction

	// request as the host should see it, lba is the track itself
	function automatic sd_req_t expect_req(input logic wr, input track_t lba);
		sd_req_t r;
		r.lba     = 32'(lba);
		r.blk_cnt = 6'd31;
		r.rd      = ~wr;
		r.wr      = wr;
		return r;
	endfunction

	task automatic check_req(input string name, input sd_req_t got, input sd_req_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got %h exp %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got %h exp %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got %h exp %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic finish_run();
		$display("summary: %0d tests run, %0d failed, %0d mismatches",
			tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	endtask

	// also notes whether busy was low while waiting
	task automatic wait_request();
		int n;
		n = 0;
		while (!(sd_req.rd || sd_req.wr) && n < REQ_TIMEOUT) begin
			if (!busy) begin
				saw_idle = 1'b1;
			end
			@(negedge clk);
			n++;
		end
		if (!(sd_req.rd || sd_req.wr)) begin
			$display("timeout: the loader raised no request within %0d cycles", REQ_TIMEOUT);
			errors++;
			timed_out = 1'b1;
		end
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		while (busy && n < IDLE_TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (busy) begin
			$display("timeout: busy still high after %0d cycles", IDLE_TIMEOUT);
			errors++;
			timed_out = 1'b1;
		end
	endtask

	// host side of one transfer, random delay before ack
	task automatic serve_request(input sd_req_t exp, input logic move, input track_t move_to);
		sd_req_t     req;
		logic [31:0] dly;
		wait_request();
		if (timed_out) begin
			return;
		end
		req = sd_req;
		check_req("sd_req", req, exp);
		// busy rises together with the request
		check_flag("busy", busy, 1'b1);
		// head moves on while the loader is busy
		if (move) begin
			track = move_to;
		end
		dly = lfsr_bits(3);
		repeat (dly + 1) @(negedge clk);
		sd_ack = 1'b1;
		@(negedge clk);
		// rd and wr gone one cycle after ack
		check_flag("sd_req.rd|wr", sd_req.rd | sd_req.wr, 1'b0);
		for (int a = 0; a < NBYTES; a++) begin
			if (req.rd) begin
				sd_buf = '{addr: `BUF_AW'(a), wdata: 8'(req.lba) ^ 8'(a), we: 1'b1};
				@(negedge clk);
			end else begin
				// one cycle read latency on sd_dout
				sd_buf = '{addr: `BUF_AW'(a), wdata: 8'h00, we: 1'b0};
				@(negedge clk);
				captured[a] = sd_dout;
			end
		end
		sd_buf.we = 1'b0;
		sd_ack    = 1'b0;
		if (exp.rd) begin
			last_lba = exp.lba[`TRACK_W-1:0];
		end else begin
			for (int a = 0; a < NBYTES; a++) begin
				check_byte("sd_dout", captured[a], written[a]);
			end
		end
	endtask

	task automatic write_drive_bytes();
		for (int a = 0; a < NBYTES; a++) begin
			written[a] = 8'(lfsr_bits(8));
			drive      = '{addr: `BUF_AW'(a), wdata: written[a], we: 1'b1};
			@(negedge clk);
		end
		drive.we = 1'b0;
	endtask

	// drive reads back what the host loaded
	task automatic check_drive_pattern();
		for (int a = 0; a < NBYTES; a++) begin
			drive = '{addr: `BUF_AW'(a), wdata: 8'h00, we: 1'b0};
			@(negedge clk);
			check_byte("drive_dout", drive_dout, 8'(last_lba) ^ 8'(a));
		end
	endtask

	task automatic apply_action(input row_t r);
		case (r.act)
			ACT_MOVE: begin
				track = r.trk;
			end
			ACT_SAVE: begin
				write_drive_bytes();
				// save toggle and head move on one edge
				save_track = ~save_track;
				track      = r.trk;
			end
			ACT_CHANGE: begin
				change = 1'b1;
				repeat (3) @(negedge clk);
				change = 1'b0;
			end
			default: begin
			end
		endcase
	endtask

	task automatic run_row(input row_t r);
		apply_action(r);
		serve_request(expect_req(r.wr0, r.lba0), r.trk2 != r.trk, r.trk2);
		if (timed_out) begin
			return;
		end
		saw_idle = 1'b0;
		if (r.n_req == 2'd2) begin
			serve_request(expect_req(r.wr1, r.lba1), 1'b0, r.trk2);
			if (timed_out) begin
				return;
			end
			check_flag("busy low between requests", saw_idle, r.idle_gap);
		end
		wait_idle();
		if (timed_out) begin
			return;
		end
		if (!(r.n_req == 2'd2 ? r.wr1 : r.wr0)) begin
			check_drive_pattern();
		end
		// no stray request once idle
		repeat (8) @(negedge clk);
		check_flag("busy", busy, 1'b0);
		check_flag("sd_req.rd|wr", sd_req.rd | sd_req.wr, 1'b0);
	endtask

	// act, trk, trk2, n_req, wr0, lba0, wr1, lba1, idle_gap
	task automatic load_table();
		rows[0]  = '{ACT_NONE, 7'd0, 7'd0, 2'd1, 1'b0, 7'd0, 1'b0, 7'd0, 1'b0};
		names[0] = "read after reset";
		rows[1]  = '{ACT_MOVE, 7'd5, 7'd5, 2'd1, 1'b0, 7'd5, 1'b0, 7'd0, 1'b0};
		names[1] = "move loads new track";
		rows[2]  = '{ACT_SAVE, 7'd5, 7'd5, 2'd1, 1'b1, 7'd5, 1'b0, 7'd0, 1'b0};
		names[2] = "save writes drive bytes";
		rows[3]  = '{ACT_CHANGE, 7'd5, 7'd5, 2'd1, 1'b0, 7'd5, 1'b0, 7'd0, 1'b0};
		names[3] = "change reloads track";
		rows[4]  = '{ACT_SAVE, 7'd9, 7'd9, 2'd2, 1'b1, 7'd5, 1'b0, 7'd9, 1'b0};
		names[4] = "save with move";
		rows[5]  = '{ACT_MOVE, 7'd12, 7'd20, 2'd2, 1'b0, 7'd12, 1'b0, 7'd20, 1'b1};
		names[5] = "move while busy";
	endtask

	initial begin
		int err_before;
		lfsr         = 32'h12bb;
		errors       = 0;
		tests_failed = 0;
		tests_run    = 0;
		saw_idle     = 1'b0;
		timed_out    = 1'b0;
		last_lba     = '0;
		reset_s      = 1'b1;
		track        = '0;
		change       = 1'b0;
		save_track   = 1'b0;
		sd_ack       = 1'b0;
		sd_buf       = '0;
		drive        = '0;
		load_table();
		repeat (3) @(negedge clk);
		reset_s = 1'b0;
		for (int i = 0; i < NROWS; i++) begin
			err_before = errors;
			run_row(rows[i]);
			tests_run++;
			if (errors == err_before) begin
				$display("test %0d %s: pass", i + 1, names[i]);
			end else begin
				tests_failed++;
				$display("test %0d %s: %0d mismatches", i + 1, names[i], errors - err_before);
			end
			if (timed_out) begin
				break;
			end
		end
		finish_run();
	end

endmodule

/* track_cache.sv */
//------------------------------
// track cache top
// syncs drive inputs, runs the loader, holds the buffer
//------------------------------
`timescale 1ns/1ps

module track_cache
	import drive_pkg::*;
	import sd_pkg::*;
(
	input  logic        clk,
	input  logic        reset_s,
	input  track_t      track,
	input  logic        change,
	input  logic        save_track,
	input  logic        sd_ack,
	input  sd_buf_t     sd_buf,
	output sd_req_t     sd_req,
	output logic [7:0]  sd_dout,
	input  drive_port_t drive,
	output logic [7:0]  drive_dout,
	output logic        busy
);

	// drive side inputs after two flops
	track_t track_s;
	logic   change_s;
	logic   save_s;

	cdc_sync #(.data_t(track_t)) track_sync_i (
		.clk (clk),
		.d   (track),
		.q   (track_s)
	);

	cdc_sync #(.data_t(logic)) change_sync_i (
		.clk (clk),
		.d   (change),
		.q   (change_s)
	);

	cdc_sync #(.data_t(logic)) save_sync_i (
		.clk (clk),
		.d   (save_track),
		.q   (save_s)
	);

	track_loader track_loader_i (
		.clk        (clk),
		.reset_s    (reset_s),
		.track      (track_s),
		.change     (change_s),
		.save_track (save_s),
		.sd_ack     (sd_ack),
		.sd_req     (sd_req),
		.busy       (busy)
	);

	// host fills or drains it, drive works on it in between
	track_buffer track_buffer_i (
		.clk        (clk),
		.sd         (sd_buf),
		.sd_dout    (sd_dout),
		.drive      (drive),
		.drive_dout (drive_dout)
	);

endmodule

/* track_buffer.sv */
//------------------------------
// one track of bytes shared by SD host and drive
// both ports read with one cycle latency
//------------------------------
`timescale 1ns/1ps
`include "disk_cfg.svh"

module track_buffer
	import drive_pkg::*;
	import sd_pkg::*;
(
	input  logic        clk,
	input  sd_buf_t     sd,
	output logic [7:0]  sd_dout,
	input  drive_port_t drive,
	output logic [7:0]  drive_dout
);

	localparam int DEPTH = 2 ** `BUF_AW;

	// whole track, no reset on the contents
	logic [7:0] mem [DEPTH];

	// writes from both ports
	// sd comes last so it wins a same address collision
	always_ff @(posedge clk) begin
		if (drive.we) begin
			mem[drive.addr] <= drive.wdata;
		end
		if (sd.we) begin
			mem[sd.addr] <= sd.wdata;
		end
	end

	// registered read for the host
	// gives old data on a write to the same byte
	always_ff @(posedge clk) begin
		sd_dout <= mem[sd.addr];
	end

	// registered read for the drive
	always_ff @(posedge clk) begin
		drive_dout <= mem[drive.addr];
	end

endmodule

/* track_loader.sv */
//------------------------------
// moves whole tracks between buffer and SD host
// saves on a save toggle and reloads on track moves
//------------------------------
`timescale 1ns/1ps
`include "disk_cfg.svh"

module track_loader
	import drive_pkg::*;
	import sd_pkg::*;
(
	input  logic    clk,
	input  logic    reset_s,
	input  track_t  track,
	input  logic    change,
	input  logic    save_track,
	input  logic    sd_ack,
	output sd_req_t sd_req,
	output logic    busy
);

	// track held in the buffer, all ones means none
	track_t cur_track;
	// requested track one cycle late
	// so a save toggle arriving with a move is seen first
	track_t track_new;
	// track number of the request in flight
	track_t req_track;

	logic old_change;
	logic old_save;
	logic old_ack;
	// reload pending from reset or media change
	logic update;
	// the request in flight is a write back
	logic saving;
	logic rd;
	logic wr;

	logic save_toggle;
	logic track_loaded;
	logic ack_fall;
	logic change_rise;

	// save_track is a toggle, any edge asks for a save
	assign save_toggle  = old_save ^ save_track;
	// upper six bits all ones counts as nothing loaded
	assign track_loaded = ~&cur_track[`TRACK_W-1:1];
	// transfer done on the first low ack after high
	assign ack_fall     = old_ack & ~sd_ack;
	assign change_rise  = change & ~old_change;

	// lba is the plain track number, block count fixed
	assign sd_req = '{
		lba:     32'(req_track),
		blk_cnt: 6'(`SD_BLK_CNT),
		rd:      rd,
		wr:      wr
	};

	always_ff @(posedge clk) begin
		track_new <= track;
	end

	always_ff @(posedge clk) begin
		if (reset_s) begin
			cur_track  <= '1;
			busy       <= 1'b0;
			rd         <= 1'b0;
			wr         <= 1'b0;
			saving     <= 1'b0;
			// read the current track on the first idle cycle
			update     <= 1'b1;
			old_change <= 1'b0;
			// no false toggle out of reset
			old_save   <= save_track;
			old_ack    <= 1'b0;
		end else begin
			old_change <= change;
			old_ack    <= sd_ack;

			// host took the request
			if (sd_ack) begin
				rd <= 1'b0;
				wr <= 1'b0;
			end

			if (busy) begin
				// hold everything until the host finishes
				if (ack_fall) begin
					saving <= 1'b0;
					if (saving && cur_track != track_new) begin
						// head moved during the save
						// fetch the new track straight away
						cur_track <= track_new;
						req_track <= track_new;
						rd        <= 1'b1;
					end else begin
						busy <= 1'b0;
					end
				end
			end else begin
				// toggle sampled only when idle so it stays pending
				old_save <= save_track;
				if (save_toggle && track_loaded) begin
					// write back what the buffer holds
					saving    <= 1'b1;
					req_track <= cur_track;
					wr        <= 1'b1;
					busy      <= 1'b1;
				end else if (cur_track != track_new || update) begin
					cur_track <= track_new;
					req_track <= track_new;
					rd        <= 1'b1;
					busy      <= 1'b1;
					update    <= 1'b0;
				end
			end

			// after the clear above so a pulse is never lost
			if (change_rise) begin
				update <= 1'b1;
			end
		end
	end

endmodule

/* cdc_sync.sv */
//------------------------------
// two flop synchronizer
// for slow or toggling inputs from the drive clock
//------------------------------
`timescale 1ns/1ps

module cdc_sync #(
	// payload type, a single bit or a whole track number
	parameter type data_t = logic
) (
	input  logic  clk,
	input  data_t d,
	output data_t q
);

	// first stage may go metastable
	data_t meta;

	// q follows d two clocks later
	always_ff @(posedge clk) begin
		meta <= d;
		q    <= meta;
	end

endmodule

/* sd_pkg.sv */
//------------------------------
// types seen from the SD block host
// import into modules that talk to the host
//------------------------------
`include "disk_cfg.svh"

package sd_pkg;

	// block request held until the host acks
	typedef struct packed {
		// first block, equal to the track number
		logic [31:0] lba;
		// number of blocks minus one
		logic [5:0] blk_cnt;
		// load the track from the card
		logic rd;
		// write the track back to the card
		logic wr;
	} sd_req_t;

	// host access into the track buffer during a transfer
	typedef struct packed {
		logic [`BUF_AW-1:0] addr;
		logic [7:0] wdata;
		// set on reads from the card
		logic we;
	} sd_buf_t;

endpackage

/* drive_pkg.sv */
//------------------------------
// types seen from the emulated drive
// import into modules that touch the drive side
//------------------------------
`include "disk_cfg.svh"

package drive_pkg;

	// head position as reported by the drive
	typedef logic [`TRACK_W-1:0] track_t;

	// one access of the drive into the track buffer
	typedef struct packed {
		// byte offset inside the track
		logic [`BUF_AW-1:0] addr;
		// byte to store when we is set
		logic [7:0] wdata;
		// write strobe
		logic we;
	} drive_port_t;

endpackage

/* disk_cfg.svh */
//------------------------------
// geometry of the track cache
// include wherever the widths are needed
//------------------------------
`ifndef DISK_CFG_SVH
`define DISK_CFG_SVH

// bits in a track number
`define TRACK_W 7

// blocks per track transfer minus one
// 32 blocks of 512 bytes each
`define SD_BLK_CNT 31

// byte address width of the track buffer
// 2**14 bytes hold one whole track
`define BUF_AW 14

`endif
